/* hw/lc3b_types.sv */
package lc3b_types;

	// ####################################################################
	// word and field types
	// ####################################################################

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;

	// opcode encodings from the LC-3b ISA
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_and = 4'b0101,
		op_not = 4'b1001
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_aluop;

	// control word, travels with the instruction down the pipe
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_aluop aluop;
		logic imm_sel;
		logic mem2_read;
		logic mem2_write;
		logic regfile_load;
		logic br_op;
	} lc3b_control;

	// ####################################################################
	// constants
	// ####################################################################

	localparam int num_regs = 8;

	// BR with nzp=000, never taken
	localparam lc3b_word nop_word = 16'h0000;

	localparam lc3b_word pc_step = 16'd2;

	// control word of a bubble, writes nothing and never branches
	localparam lc3b_control nop_cw = '{
		opcode: op_br,
		aluop: alu_pass,
		imm_sel: 1'b0,
		mem2_read: 1'b0,
		mem2_write: 1'b0,
		regfile_load: 1'b0,
		br_op: 1'b0
	};

endpackage : lc3b_types

/* hw/pipe_if.sv */
interface pipe_if
	import lc3b_types::*;
();

	// one instruction's state between two stages
	logic valid;
	lc3b_word ir;
	lc3b_word pc;
	lc3b_control cw;
	lc3b_word sr1;
	lc3b_word sr2;
	lc3b_word alu;
	lc3b_word mdr;

	modport producer (output valid, ir, pc, cw, sr1, sr2, alu, mdr);

	modport consumer (input valid, ir, pc, cw, sr1, sr2, alu, mdr);

endinterface : pipe_if

/* hw/instruction_fetch.sv */
module instruction_fetch
	import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic branch_taken,
	input lc3b_word br_target,
	output lc3b_word mem_addr1,
	output logic mem_read1,
	input lc3b_word mem_rdata1,
	pipe_if.producer if_id
);

	lc3b_word pc;

	// instruction port reads every cycle
	assign mem_addr1 = pc;
	assign mem_read1 = 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			if_id.valid <= 1'b0;
		end else begin
			pc <= branch_taken ? br_target : pc + pc_step;
			if_id.valid <= !branch_taken;
		end
	end

	// IF/ID payload, squashed slot gets a bubble
	always_ff @(posedge clk) begin
		if_id.pc <= pc;
		if_id.ir <= branch_taken ? nop_word : mem_rdata1;
	end

	// not known before decode
	assign if_id.cw = nop_cw;
	assign if_id.sr1 = '0;
	assign if_id.sr2 = '0;
	assign if_id.alu = '0;
	assign if_id.mdr = '0;

endmodule : instruction_fetch

/* hw/instruction_decode.sv */
module instruction_decode
	import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	input logic branch_taken,
	pipe_if.consumer if_id,
	pipe_if.producer id_ex,
	input logic regfile_load,
	input lc3b_reg dest,
	input lc3b_word wb_data,
	input logic cc_load,
	input lc3b_nzp cc_value
);

	lc3b_word regs [num_regs];
	lc3b_nzp nzp;
	lc3b_control cw;
	lc3b_reg sr1_idx;
	lc3b_reg sr2_idx;
	lc3b_word sr1_val;
	lc3b_word sr2_val;
	lc3b_nzp nzp_now;

	// ####################################################################
	// register file and condition codes
	// ####################################################################

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i[2:0]] <= '0;
			end
			nzp <= 3'b010;
		end else begin
			if (regfile_load) begin
				regs[dest] <= wb_data;
			end
			if (cc_load) begin
				nzp <= cc_value;
			end
		end
	end

	// ####################################################################
	// control word
	// ####################################################################

	always_comb begin
		cw = nop_cw;
		case (if_id.ir[15:12])
			op_add, op_and: begin
				cw.opcode = (if_id.ir[15:12] == op_add) ? op_add : op_and;
				cw.aluop = (if_id.ir[15:12] == op_add) ? alu_add : alu_and;
				cw.imm_sel = if_id.ir[5];
				cw.regfile_load = 1'b1;
			end
			op_not: begin
				cw.opcode = op_not;
				cw.aluop = alu_not;
				cw.regfile_load = 1'b1;
			end
			op_ldr: begin
				cw.opcode = op_ldr;
				cw.aluop = alu_add;
				cw.imm_sel = 1'b1;
				cw.mem2_read = 1'b1;
				cw.regfile_load = 1'b1;
			end
			op_str: begin
				cw.opcode = op_str;
				cw.aluop = alu_add;
				cw.imm_sel = 1'b1;
				cw.mem2_write = 1'b1;
			end
			op_br: begin
				cw.br_op = 1'b1;
			end
			// anything else is a bubble
			default: cw = nop_cw;
		endcase
	end

	// STR reads its data register through the sr2 port
	assign sr1_idx = if_id.ir[8:6];
	assign sr2_idx = (cw.opcode == op_str) ? if_id.ir[11:9] : if_id.ir[2:0];

	// writes in this cycle are visible to the read
	assign sr1_val = (regfile_load && dest == sr1_idx) ? wb_data : regs[sr1_idx];
	assign sr2_val = (regfile_load && dest == sr2_idx) ? wb_data : regs[sr2_idx];
	assign nzp_now = cc_load ? cc_value : nzp;

	always_ff @(posedge clk) begin
		if (reset) begin
			id_ex.valid <= 1'b0;
		end else begin
			id_ex.valid <= if_id.valid && !branch_taken;
		end
	end

	// ID/EX payload with a BR's condition code in the sr1 slot
	always_ff @(posedge clk) begin
		id_ex.pc <= if_id.pc;
		id_ex.ir <= branch_taken ? nop_word : if_id.ir;
		id_ex.cw <= branch_taken ? nop_cw : cw;
		id_ex.sr1 <= (cw.opcode == op_br) ? {13'b0, nzp_now} : sr1_val;
		id_ex.sr2 <= sr2_val;
	end

	assign id_ex.alu = '0;
	assign id_ex.mdr = '0;

endmodule : instruction_decode

/* hw/execution_module.sv */
module execution_module
	import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	pipe_if.consumer id_ex,
	pipe_if.producer ex_mem,
	output logic branch_taken,
	output lc3b_word br_target
);

	lc3b_word imm5_sext;
	lc3b_word off6_sext;
	lc3b_word off9_sext;
	lc3b_word operand_b;
	lc3b_word alu_out;
	lc3b_nzp cur_cc;

	assign imm5_sext = {{11{id_ex.ir[4]}}, id_ex.ir[4:0]};
	assign off6_sext = {{9{id_ex.ir[5]}}, id_ex.ir[5:0], 1'b0};
	assign off9_sext = {{6{id_ex.ir[8]}}, id_ex.ir[8:0], 1'b0};

	// loads and stores form base plus word offset
	always_comb begin
		if (!id_ex.cw.imm_sel) begin
			operand_b = id_ex.sr2;
		end else if (id_ex.cw.opcode == op_ldr || id_ex.cw.opcode == op_str) begin
			operand_b = off6_sext;
		end else begin
			operand_b = imm5_sext;
		end
	end

	always_comb begin
		case (id_ex.cw.aluop)
			alu_add: alu_out = id_ex.sr1 + operand_b;
			alu_and: alu_out = id_ex.sr1 & operand_b;
			alu_not: alu_out = ~id_ex.sr1;
			default: alu_out = id_ex.sr1;
		endcase
	end

	// branch resolves here, nzp came along in sr1
	assign cur_cc = id_ex.sr1[2:0];
	assign br_target = id_ex.pc + pc_step + off9_sext;
	assign branch_taken = id_ex.valid && id_ex.cw.br_op && (|(id_ex.ir[11:9] & cur_cc));

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_mem.valid <= 1'b0;
		end else begin
			ex_mem.valid <= id_ex.valid;
		end
	end

	always_ff @(posedge clk) begin
		ex_mem.ir <= id_ex.ir;
		ex_mem.pc <= id_ex.pc;
		ex_mem.cw <= id_ex.cw;
		ex_mem.sr1 <= id_ex.sr1;
		// store data
		ex_mem.sr2 <= id_ex.sr2;
		ex_mem.alu <= alu_out;
	end

	assign ex_mem.mdr = '0;

endmodule : execution_module

/* hw/memory_module.sv */
module memory_module
	import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	pipe_if.consumer ex_mem,
	pipe_if.producer mem_wb,
	output lc3b_word mem_addr2,
	output logic mem_read2,
	output logic mem_write2,
	output lc3b_word mem_wdata2,
	input lc3b_word mem_rdata2
);

	// data port, address from the ALU
	assign mem_addr2 = ex_mem.alu;
	assign mem_read2 = ex_mem.valid && ex_mem.cw.mem2_read;
	assign mem_write2 = ex_mem.valid && ex_mem.cw.mem2_write;
	assign mem_wdata2 = ex_mem.sr2;

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_wb.valid <= 1'b0;
		end else begin
			mem_wb.valid <= ex_mem.valid;
		end
	end

	// MEM/WB payload, load data lands in mdr
	always_ff @(posedge clk) begin
		mem_wb.ir <= ex_mem.ir;
		mem_wb.pc <= ex_mem.pc;
		mem_wb.cw <= ex_mem.cw;
		mem_wb.sr1 <= ex_mem.sr1;
		mem_wb.sr2 <= ex_mem.sr2;
		mem_wb.alu <= ex_mem.alu;
		mem_wb.mdr <= mem_rdata2;
	end

endmodule : memory_module

/* hw/writeback_module.sv */
module writeback_module
	import lc3b_types::*;
(
	pipe_if.consumer mem_wb,
	output logic regfile_load,
	output lc3b_reg dest,
	output lc3b_word wb_data,
	output logic cc_load,
	output lc3b_nzp cc_value
);

	// ####################################################################
	// result select and condition codes
	// ####################################################################

	assign wb_data = (mem_wb.cw.opcode == op_ldr) ? mem_wb.mdr : mem_wb.alu;

	assign dest = mem_wb.ir[11:9];
	assign regfile_load = mem_wb.valid && mem_wb.cw.regfile_load;

	// every register write also sets nzp
	assign cc_load = regfile_load;

	always_comb begin
		if (wb_data[15]) begin
			cc_value = 3'b100;
		end else if (wb_data == '0) begin
			cc_value = 3'b010;
		end else begin
			cc_value = 3'b001;
		end
	end

endmodule : writeback_module

/* hw/cpu_datapath.sv */
module cpu_datapath
	import lc3b_types::*;
(
	input logic clk,
	input logic reset,
	output lc3b_word mem_addr1,
	output logic mem_read1,
	input lc3b_word mem_rdata1,
	output lc3b_word mem_addr2,
	output logic mem_read2,
	output logic mem_write2,
	input lc3b_word mem_rdata2,
	output lc3b_word mem_wdata2
);

	// stage registers
	pipe_if if_id();
	pipe_if id_ex();
	pipe_if ex_mem();
	pipe_if mem_wb();

	// redirect from execute
	logic branch_taken;
	lc3b_word br_target;

	// register write from writeback
	logic regfile_load;
	lc3b_reg dest;
	lc3b_word wb_data;
	logic cc_load;
	lc3b_nzp cc_value;

	instruction_fetch if_stage (
		.clk(clk),
		.reset(reset),
		.branch_taken(branch_taken),
		.br_target(br_target),
		.mem_addr1(mem_addr1),
		.mem_read1(mem_read1),
		.mem_rdata1(mem_rdata1),
		.if_id(if_id.producer)
	);

	instruction_decode id_stage (
		.clk(clk),
		.reset(reset),
		.branch_taken(branch_taken),
		.if_id(if_id.consumer),
		.id_ex(id_ex.producer),
		.regfile_load(regfile_load),
		.dest(dest),
		.wb_data(wb_data),
		.cc_load(cc_load),
		.cc_value(cc_value)
	);

	execution_module ex_stage (
		.clk(clk),
		.reset(reset),
		.id_ex(id_ex.consumer),
		.ex_mem(ex_mem.producer),
		.branch_taken(branch_taken),
		.br_target(br_target)
	);

	memory_module mem_stage (
		.clk(clk),
		.reset(reset),
		.ex_mem(ex_mem.consumer),
		.mem_wb(mem_wb.producer),
		.mem_addr2(mem_addr2),
		.mem_read2(mem_read2),
		.mem_write2(mem_write2),
		.mem_wdata2(mem_wdata2),
		.mem_rdata2(mem_rdata2)
	);

	writeback_module wb_stage (
		.mem_wb(mem_wb.consumer),
		.regfile_load(regfile_load),
		.dest(dest),
		.wb_data(wb_data),
		.cc_load(cc_load),
		.cc_value(cc_value)
	);

endmodule : cpu_datapath

/* dv/cpu_tb.sv */
module cpu_tb
	import lc3b_types::*;
();

	logic clk;
	logic reset;
	lc3b_word mem_addr1;
	logic mem_read1;
	lc3b_word mem_rdata1;
	lc3b_word mem_addr2;
	logic mem_read2;
	logic mem_write2;
	lc3b_word mem_rdata2;
	lc3b_word mem_wdata2;

	lc3b_word imem [256];
	lc3b_word dmem [256];
	lc3b_word golden [128];
	lc3b_word exp_addr [32];
	lc3b_word exp_data [32];

	int n_prog;
	int n_data;
	int n_stores;
	int store_count = 0;
	logic loaded = 1'b0;

	cpu_datapath i_dut (
		.clk(clk),
		.reset(reset),
		.mem_addr1(mem_addr1),
		.mem_read1(mem_read1),
		.mem_rdata1(mem_rdata1),
		.mem_addr2(mem_addr2),
		.mem_read2(mem_read2),
		.mem_write2(mem_write2),
		.mem_rdata2(mem_rdata2),
		.mem_wdata2(mem_wdata2)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ####################################################################
	// word addressed memory models
	// ####################################################################

	// reads return data only while the port strobe is high
	assign mem_rdata1 = mem_read1 ? imem[mem_addr1[8:1]] : nop_word;
	assign mem_rdata2 = mem_read2 ? dmem[mem_addr2[8:1]] : 16'hdead;

	task automatic stop_on_failure;
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_store(input int idx, input lc3b_word got_addr, input lc3b_word got_data,
			input lc3b_word want_addr, input lc3b_word want_data);
		if (got_addr !== want_addr || got_data !== want_data) begin
			$display("MISMATCH at %0t: store %0d wrote %h to %h, expected %h to %h",
				$time, idx, got_data, got_addr, want_data, want_addr);
			stop_on_failure();
		end
	endtask

	task automatic check_count(input int got, input int want);
		if (got != want) begin
			$display("MISMATCH at %0t: %0d stores seen, expected %0d", $time, got, want);
			stop_on_failure();
		end
	endtask

	// data memory write and store checks
	always @(posedge clk) begin
		if (mem_write2 === 1'b1) begin
			dmem[mem_addr2[8:1]] <= mem_wdata2;
			if (reset) begin
				$display("a store was issued at %0t while reset was asserted", $time);
				stop_on_failure();
			end else if (store_count >= n_stores) begin
				check_count(store_count + 1, n_stores);
			end else begin
				check_store(store_count, mem_addr2, mem_wdata2,
					exp_addr[store_count[4:0]], exp_data[store_count[4:0]]);
				store_count = store_count + 1;
			end
		end
	end

	// ####################################################################
	// golden file, reset and end of run
	// ####################################################################

	initial begin
		int p;
		lc3b_word a;
		reset = 1'b1;
		for (int i = 0; i < 256; i++) begin
			// never-taken BR with the slot number in its offset field
			imem[i[7:0]] = {8'h00, i[7:0]};
			dmem[i[7:0]] <= {~i[7:0], i[7:0]};
		end
		for (int i = 0; i < 128; i++) begin
			golden[i[6:0]] = '0;
		end
		$readmemh("dv/cpu_golden.txt", golden);
		n_prog = int'(golden[0]);
		n_data = int'(golden[1]);
		n_stores = int'(golden[2]);
		if (n_prog == 0 || n_prog > 64 || n_data > 16 || n_stores == 0 || n_stores > 32
				|| 3 + n_prog + 2 * (n_data + n_stores) > 128) begin
			$display("the golden file is missing or its header counts are out of range");
			stop_on_failure();
		end
		p = 3;
		for (int i = 0; i < n_prog; i++) begin
			imem[i[7:0]] = golden[p[6:0]];
			p = p + 1;
		end
		for (int i = 0; i < n_data; i++) begin
			a = golden[p[6:0]];
			dmem[a[8:1]] <= golden[p[6:0] + 7'd1];
			p = p + 2;
		end
		for (int i = 0; i < n_stores; i++) begin
			exp_addr[i[4:0]] = golden[p[6:0]];
			exp_data[i[4:0]] = golden[p[6:0] + 7'd1];
			p = p + 2;
		end
		loaded = 1'b1;

		repeat (8) @(posedge clk);
		reset <= 1'b0;

		wait (store_count == n_stores);
		// the final spin loop keeps running here
		repeat (20) @(negedge clk);
		$display("Test passed");
		$finish;
	end

	// watchdog
	initial begin
		wait (loaded);
		repeat (20 * n_prog + 200) @(posedge clk);
		$display("timeout: only %0d of %0d expected stores appeared within %0d cycles",
			store_count, n_stores, 20 * n_prog + 200);
		stop_on_failure();
	end

endmodule : cpu_tb

/* files.f */
hw/lc3b_types.sv
hw/pipe_if.sv
hw/instruction_fetch.sv
hw/instruction_decode.sv
hw/execution_module.sv
hw/memory_module.sv
hw/writeback_module.sv
hw/cpu_datapath.sv
dv/cpu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the LC-3b pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f files.f --top-module cpu_tb -o cpu_sim > sim.log 2>&1 &&
	./obj_dir/cpu_sim >> sim.log 2>&1 ||
	echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

/* dv/cpu_golden.txt */
// header: program word count, data word count, store count; then program words,
// then data address/value pairs, then expected store address/data pairs in order
0024 0003 000a
// program, word 0 at address 0000
6e04 1227 143d 6c05 1678 9a7f 1842 55b0 // base load, ADD/AND/NOT setup
77c1 5385 79c2 7bc3 75c4 73c5 // stores of the arithmetic results
67fe 1901 0000 0000 77c6 9b3f 1cc4 // LDR with negative offset, carried chain
0000 0000 7bc7 7dc8 // stores of the chain
0202 73c9 75ca // BRp taken over two stores
1220 0000 0000 0000 0a01 79cb 73cc 0fff // BRnp falls through, then spin
// initial data words
0008 0100
000a 5a3c
00fc 1234
// expected stores
0102 ffff
0104 0004
0106 fff8
0108 5a30
010a 5a38
010c 1234
010e a5c3
0110 6c70
0116 5a3c
0118 0000
